// ==== branch_profiler_top.f ====
common/profiler_cfg_pkg.sv
common/profiler_bus_pkg.sv
hw/axil_reg_decode.sv
profiler/profile_table.sv
hw/axil_read_result.sv
hw/branch_profiler_top.sv
verification/branch_profiler_checker.sv
verification/branch_profiler_tb.sv

// ==== Makefile ====
TOP = branch_profiler_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f branch_profiler_top.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== verification/branch_profiler_tb.sv ====
`default_nettype none

module branch_profiler_tb;

    localparam int num_entries   = profiler_cfg_pkg::default_num_entries;
    localparam int count_width   = profiler_cfg_pkg::default_count_width;
    localparam int sbb_max_back  = profiler_cfg_pkg::default_sbb_max_back;
    localparam int hot_threshold = profiler_cfg_pkg::default_hot_threshold;
    localparam int count_max     = (1 << count_width) - 1;
    localparam logic [31:0] hot_pc = 32'h8000_0200;

    // Reset, locked branches, four install rounds, aging, eight table readbacks of up to
    // three reads per entry plus a few control accesses at about ten cycles each
    localparam int test_cycles = 5 + 50 + 4 * 100 + 60 + (8 * 3 * num_entries + 8) * 10;
    localparam int cycle_limit = 3 * test_cycles;

    logic clk = 1'b0;
    logic rst;
    logic branch_valid;
    logic branch_taken;
    logic [31:0] branch_pc;
    logic signed [20:0] branch_offset;
    logic s_axil_awvalid, s_axil_wvalid, s_axil_bready, s_axil_arvalid, s_axil_rready;
    logic [31:0] s_axil_awaddr, s_axil_wdata, s_axil_araddr;
    logic s_axil_awready, s_axil_wready, s_axil_bvalid, s_axil_arready, s_axil_rvalid;
    logic [1:0] s_axil_bresp, s_axil_rresp;
    logic [31:0] s_axil_rdata;
    logic hot_irq;

    integer seed = 32'h0e58b4d4;
    int cycle_count = 0;

    // Reference model state
    logic [31:0] m_addr [num_entries];
    bit m_valid [num_entries];
    int m_count [num_entries];
    bit m_lock = 1'b1;
    bit m_irq = 1'b0;
    logic [num_entries-1:0] m_over_q = '0;

    branch_profiler_top #(
        .num_entries   (num_entries),
        .count_width   (count_width),
        .sbb_max_back  (sbb_max_back),
        .hot_threshold (hot_threshold)
    ) dut0 (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic coin_flip();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic logic [31:0] entry_word(input int idx, input logic [1:0] field);
        profiler_bus_pkg::prof_addr_u a;
        a = '0;
        a.entry.index = idx[profiler_cfg_pkg::max_index_width-1:0];
        a.entry.field = field;
        return 32'(a);
    endfunction

    function automatic logic [31:0] ctrl_word(input logic [3:0] sel);
        profiler_bus_pkg::prof_addr_u a;
        a = '0;
        a.ctrl.region = 1'b1;
        a.ctrl.sel = sel;
        return 32'(a);
    endfunction

    // Table rules for hits, aging on a saturated hit and installs into a free or coldest slot
    task automatic apply_branch(input logic [31:0] pc, input int off);
        int hit;
        int victim;
        hit = -1;
        victim = -1;
        for (int i = 0; i < num_entries; i++)
            if (m_valid[i] && m_addr[i] == pc)
                hit = i;
        if (hit >= 0) begin
            if (m_count[hit] == count_max) begin
                for (int i = 0; i < num_entries; i++)
                    m_count[i] = m_count[i] / 2;
                m_count[hit] = count_max / 2 + 1;
            end else begin
                m_count[hit]++;
            end
        end else if (off < 0 && off > -sbb_max_back) begin
            for (int i = 0; i < num_entries; i++)
                if (!m_valid[i] && victim < 0)
                    victim = i;
            if (victim < 0) begin
                victim = 0;
                for (int i = 1; i < num_entries; i++)
                    if (m_count[i] < m_count[victim])
                        victim = i;
            end
            m_valid[victim] = 1'b1;
            m_addr[victim] = pc;
            m_count[victim] = 1;
        end
    endtask

    always @(posedge clk) begin
        logic [num_entries-1:0] over;
        if (rst) begin
            for (int i = 0; i < num_entries; i++) begin
                m_valid[i] = 1'b0;
                m_count[i] = 0;
            end
            m_irq = 1'b0;
            m_over_q = '0;
        end else begin
            // Interrupt follows the edge where a count first reached the threshold
            for (int i = 0; i < num_entries; i++)
                over[i] = m_count[i] >= hot_threshold;
            m_irq = (|(over & ~m_over_q)) && !m_irq;
            m_over_q = over;
            if (branch_valid && branch_taken && !m_lock)
                apply_branch(branch_pc, branch_offset);
        end
    end

    always @(negedge clk) begin
        if (!rst)
            check_value("hot_irq", hot_irq, m_irq);
    end

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
        int lat;
        @(posedge clk);
        s_axil_arvalid <= 1'b1;
        s_axil_araddr <= addr;
        @(negedge clk);
        while (!s_axil_arready)
            @(negedge clk);
        @(posedge clk);
        s_axil_arvalid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!s_axil_rvalid && lat < 8);
        check_value("read latency", lat, 2);
        check_value("s_axil_rresp", s_axil_rresp, profiler_bus_pkg::axi_resp_okay);
        data = s_axil_rdata;
        while (!s_axil_rready) begin
            @(posedge clk);
            s_axil_rready <= coin_flip();
            @(negedge clk);
            check_value("s_axil_rvalid", s_axil_rvalid, 1);
            check_value("s_axil_rdata", s_axil_rdata, data);
            check_value("s_axil_arready", s_axil_arready, 0);
        end
        @(posedge clk);
        s_axil_rready <= 1'b0;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        @(posedge clk);
        s_axil_awvalid <= 1'b1;
        s_axil_wvalid <= 1'b1;
        s_axil_awaddr <= addr;
        s_axil_wdata <= data;
        @(negedge clk);
        while (!s_axil_awready)
            @(negedge clk);
        check_value("s_axil_wready", s_axil_wready, 1);
        @(posedge clk);
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid <= 1'b0;
        @(negedge clk);
        check_value("s_axil_bvalid", s_axil_bvalid, 1);
        check_value("s_axil_bresp", s_axil_bresp, exp_resp);
        while (!s_axil_bready) begin
            @(posedge clk);
            s_axil_bready <= coin_flip();
            @(negedge clk);
            check_value("s_axil_bvalid", s_axil_bvalid, 1);
            check_value("s_axil_bresp", s_axil_bresp, exp_resp);
        end
        @(posedge clk);
        s_axil_bready <= 1'b0;
    endtask

    // Small PC set with mixed offsets around the loop window edge
    task automatic drive_branches(input int n, input bit focus);
        int r;
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            r = $random(seed);
            if (focus) begin
                branch_valid <= 1'b1;
                branch_taken <= 1'b1;
                branch_pc <= hot_pc;
                branch_offset <= -21'sd32;
            end else begin
                branch_valid <= r[0] | r[1];
                branch_taken <= r[2] | r[3];
                branch_pc <= 32'h8000_0100 + ((r >> 4) & 15) * 4;
                case ((r >> 8) & 3)
                    0: branch_offset <= 21'sd16;
                    1: branch_offset <= -21'sd400;
                    default: branch_offset <= 21'(-(4 + ((r >> 10) & 252)));
                endcase
            end
        end
        @(posedge clk);
        branch_valid <= 1'b0;
    endtask

    task automatic check_table();
        logic [31:0] d;
        for (int i = 0; i < num_entries; i++) begin
            axi_read(entry_word(i, profiler_bus_pkg::field_valid), d);
            check_value($sformatf("entry %0d valid", i), d, 32'(m_valid[i]));
            // Odd entries are read through the wrapped index
            axi_read(entry_word(i + (i % 2) * num_entries, profiler_bus_pkg::field_count), d);
            check_value($sformatf("entry %0d count", i), d, 32'(m_count[i]));
            if (m_valid[i]) begin
                axi_read(entry_word(i, profiler_bus_pkg::field_addr), d);
                check_value($sformatf("entry %0d addr", i), d, m_addr[i]);
            end
        end
    endtask

    initial begin
        logic [31:0] d;
        rst = 1'b1;
        branch_valid = 1'b0;
        branch_taken = 1'b0;
        branch_pc = '0;
        branch_offset = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid = 1'b0;
        s_axil_awaddr = '0;
        s_axil_wdata = '0;
        s_axil_bready = 1'b0;
        s_axil_arvalid = 1'b0;
        s_axil_araddr = '0;
        s_axil_rready = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        axi_read(ctrl_word(profiler_bus_pkg::reg_lock), d);
        check_value("lock register", d, 1);
        check_table();
        drive_branches(50, 1'b0);
        check_table();

        axi_write(ctrl_word(profiler_bus_pkg::reg_lock), 32'h0, profiler_bus_pkg::axi_resp_okay);
        m_lock = 1'b0;
        axi_read(ctrl_word(profiler_bus_pkg::reg_lock), d);
        check_value("lock register", d, 0);
        repeat (4) begin
            drive_branches(100, 1'b0);
            check_table();
        end

        // One loop hammered past saturation
        drive_branches(60, 1'b1);
        check_table();

        axi_write(entry_word(3, profiler_bus_pkg::field_count), 32'h5,
                  profiler_bus_pkg::axi_resp_slverr);
        axi_write(ctrl_word(profiler_bus_pkg::reg_info), 32'hffff, profiler_bus_pkg::axi_resp_okay);
        axi_read(ctrl_word(profiler_bus_pkg::reg_info), d);
        check_value("info register", d, (count_width << 8) | num_entries);
        axi_write(ctrl_word(profiler_bus_pkg::reg_lock), 32'h1, profiler_bus_pkg::axi_resp_okay);
        m_lock = 1'b1;
        axi_read(ctrl_word(profiler_bus_pkg::reg_lock), d);
        check_value("lock register", d, 1);
        check_table();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/branch_profiler_checker.sv ====
`default_nettype none

module branch_profiler_checker (
    input wire                               clk,
    input wire                               rst,
    input wire                               s_axil_rvalid,
    input wire                               s_axil_rready,
    input wire [profiler_cfg_pkg::xlen-1:0]  s_axil_rdata,
    input wire                               s_axil_bvalid,
    input wire                               s_axil_bready,
    input wire                               hot_irq
);

    // R channel holds under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
        else $error("RVALID or RDATA changed while RREADY was low");

    assert property (@(posedge clk) disable iff (rst)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else $error("BVALID dropped while BREADY was low");

    // Interrupt is a single pulse
    assert property (@(posedge clk) disable iff (rst) hot_irq |=> !hot_irq)
        else $error("hot_irq was high two cycles running");

endmodule

bind branch_profiler_top branch_profiler_checker checker0 (
    .clk           (clk),
    .rst           (rst),
    .s_axil_rvalid (s_axil_rvalid),
    .s_axil_rready (s_axil_rready),
    .s_axil_rdata  (s_axil_rdata),
    .s_axil_bvalid (s_axil_bvalid),
    .s_axil_bready (s_axil_bready),
    .hot_irq       (hot_irq)
);

`default_nettype wire

// ==== hw/branch_profiler_top.sv ====
`default_nettype none

module branch_profiler_top #(
    parameter int num_entries   = profiler_cfg_pkg::default_num_entries,
    parameter int count_width   = profiler_cfg_pkg::default_count_width,
    parameter int sbb_max_back  = profiler_cfg_pkg::default_sbb_max_back,
    parameter int hot_threshold = profiler_cfg_pkg::default_hot_threshold
) (
    input  wire                                clk,
    input  wire                                rst,

    input  wire                                branch_valid,
    input  wire                                branch_taken,
    input  wire  [profiler_cfg_pkg::xlen-1:0]  branch_pc,
    input  wire  signed [20:0]                 branch_offset,

    input  wire                                s_axil_awvalid,
    output logic                               s_axil_awready,
    input  wire  [profiler_cfg_pkg::xlen-1:0]  s_axil_awaddr,
    input  wire                                s_axil_wvalid,
    output logic                               s_axil_wready,
    input  wire  [profiler_cfg_pkg::xlen-1:0]  s_axil_wdata,
    output logic                               s_axil_bvalid,
    output logic [1:0]                         s_axil_bresp,
    input  wire                                s_axil_bready,
    input  wire                                s_axil_arvalid,
    output logic                               s_axil_arready,
    input  wire  [profiler_cfg_pkg::xlen-1:0]  s_axil_araddr,
    output logic                               s_axil_rvalid,
    input  wire                                s_axil_rready,
    output logic [profiler_cfg_pkg::xlen-1:0]  s_axil_rdata,
    output logic [1:0]                         s_axil_rresp,

    output logic                               hot_irq
);

    logic                               lock;
    logic                               rd_busy;
    logic                               rd_req;
    logic                               rd_is_ctrl;
    logic [3:0]                         rd_reg_sel;
    logic [$clog2(num_entries)-1:0]     rd_index;
    logic [1:0]                         rd_field;
    logic [profiler_cfg_pkg::xlen-1:0]  rd_data;

    axil_reg_decode #(
        .num_entries (num_entries)
    ) decode0 (
        .clk            (clk),
        .rst            (rst),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bready  (s_axil_bready),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_araddr  (s_axil_araddr),
        .rd_busy        (rd_busy),
        .rd_req         (rd_req),
        .rd_is_ctrl     (rd_is_ctrl),
        .rd_reg_sel     (rd_reg_sel),
        .rd_index       (rd_index),
        .rd_field       (rd_field),
        .lock           (lock)
    );

    profile_table #(
        .num_entries   (num_entries),
        .count_width   (count_width),
        .sbb_max_back  (sbb_max_back),
        .hot_threshold (hot_threshold)
    ) table0 (
        .clk           (clk),
        .rst           (rst),
        .branch_valid  (branch_valid),
        .branch_taken  (branch_taken),
        .branch_pc     (branch_pc),
        .branch_offset (branch_offset),
        .lock          (lock),
        .rd_index      (rd_index),
        .rd_field      (rd_field),
        .rd_data       (rd_data),
        .hot_irq       (hot_irq)
    );

    axil_read_result #(
        .num_entries (num_entries),
        .count_width (count_width)
    ) result0 (
        .clk           (clk),
        .rst           (rst),
        .rd_req        (rd_req),
        .rd_is_ctrl    (rd_is_ctrl),
        .rd_reg_sel    (rd_reg_sel),
        .rd_data       (rd_data),
        .lock          (lock),
        .s_axil_rready (s_axil_rready),
        .s_axil_rvalid (s_axil_rvalid),
        .s_axil_rdata  (s_axil_rdata),
        .s_axil_rresp  (s_axil_rresp),
        .rd_busy       (rd_busy)
    );

endmodule

`default_nettype wire

// ==== hw/axil_read_result.sv ====
`default_nettype none

module axil_read_result #(
    parameter int num_entries = 8,
    parameter int count_width = 4
) (
    input  wire                                clk,
    input  wire                                rst,

    input  wire                                rd_req,
    input  wire                                rd_is_ctrl,
    input  wire  [3:0]                         rd_reg_sel,
    input  wire  [profiler_cfg_pkg::xlen-1:0]  rd_data,
    input  wire                                lock,

    input  wire                                s_axil_rready,
    output logic                               s_axil_rvalid,
    output logic [profiler_cfg_pkg::xlen-1:0]  s_axil_rdata,
    output logic [1:0]                         s_axil_rresp,

    output logic                               rd_busy
);

    localparam int data_width = profiler_cfg_pkg::xlen;

    logic [data_width-1:0] ctrl_data;
    logic [data_width-1:0] sel_data;

    // Info register packs entries low and count width above
    always_comb begin
        case (rd_reg_sel)
            profiler_bus_pkg::reg_lock: ctrl_data = data_width'(lock);
            profiler_bus_pkg::reg_info: ctrl_data = data_width'({8'(count_width), 8'(num_entries)});
            default:                    ctrl_data = '0;
        endcase
    end

    assign sel_data = rd_is_ctrl ? ctrl_data : rd_data;

    always_ff @(posedge clk) begin
        if (rst)
            s_axil_rvalid <= 1'b0;
        else if (rd_req)
            s_axil_rvalid <= 1'b1;
        else if (s_axil_rready)
            s_axil_rvalid <= 1'b0;
    end

    // Held until the master takes it
    always_ff @(posedge clk) begin
        if (rd_req)
            s_axil_rdata <= sel_data;
    end

    assign s_axil_rresp = profiler_bus_pkg::axi_resp_okay;
    assign rd_busy      = s_axil_rvalid;

endmodule

`default_nettype wire

// ==== profiler/profile_table.sv ====
`default_nettype none

module profile_table #(
    parameter int num_entries   = 8,
    parameter int count_width   = 4,
    parameter int sbb_max_back  = 256,
    parameter int hot_threshold = 12
) (
    input  wire                                clk,
    input  wire                                rst,

    input  wire                                branch_valid,
    input  wire                                branch_taken,
    input  wire  [profiler_cfg_pkg::xlen-1:0]  branch_pc,
    input  wire  signed [20:0]                 branch_offset,

    input  wire                                lock,
    input  wire  [$clog2(num_entries)-1:0]     rd_index,
    input  wire  [1:0]                         rd_field,
    output logic [profiler_cfg_pkg::xlen-1:0]  rd_data,

    output logic                               hot_irq
);

    localparam int index_width = $clog2(num_entries);
    localparam int data_width  = profiler_cfg_pkg::xlen;

    logic [data_width-1:0]  entry_addr  [num_entries];
    logic [num_entries-1:0] entry_valid;
    logic [count_width-1:0] entry_count [num_entries];
    logic [count_width-1:0] next_count  [num_entries];

    logic                   qualify;
    logic                   short_back;
    logic [num_entries-1:0] addr_match;
    logic [num_entries-1:0] at_max;
    logic                   halve;
    logic                   install;

    logic [index_width-1:0] free_slot;
    logic                   any_free;
    logic [index_width-1:0] coldest_slot;
    logic [count_width-1:0] coldest_count;
    logic [index_width-1:0] victim;

    logic [num_entries-1:0] over_thresh;
    logic [num_entries-1:0] over_thresh_q;

    assign qualify = branch_valid && branch_taken && !lock;

    // Backward and within the loop window
    assign short_back = (branch_offset < 0) && (int'(branch_offset) > -sbb_max_back);

    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            addr_match[i] = qualify && entry_valid[i] && (entry_addr[i] == branch_pc);
            at_max[i]     = &entry_count[i];
        end
    end

    // A hit on a saturated entry ages the whole table
    assign halve   = |(addr_match & at_max);
    assign install = qualify && short_back && !(|addr_match);

    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            next_count[i] = halve ? entry_count[i] >> 1 : entry_count[i];
            if (addr_match[i])
                next_count[i] = next_count[i] + 1'b1;
        end
    end

    // Lowest invalid slot
    always_comb begin
        free_slot = '0;
        any_free  = 1'b0;
        for (int i = num_entries - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                any_free  = 1'b1;
                free_slot = index_width'(i);
            end
        end
    end

    // Lowest slot with the smallest count
    always_comb begin
        coldest_slot  = '0;
        coldest_count = entry_count[0];
        for (int i = 1; i < num_entries; i++) begin
            if (entry_count[i] < coldest_count) begin
                coldest_count = entry_count[i];
                coldest_slot  = index_width'(i);
            end
        end
    end

    assign victim = any_free ? free_slot : coldest_slot;

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
            for (int i = 0; i < num_entries; i++)
                entry_count[i] <= '0;
        end else begin
            for (int i = 0; i < num_entries; i++)
                entry_count[i] <= next_count[i];
            if (install) begin
                entry_valid[victim] <= 1'b1;
                entry_count[victim] <= count_width'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (install)
            entry_addr[victim] <= branch_pc;
    end

    always_comb begin
        case (rd_field)
            profiler_bus_pkg::field_addr:  rd_data = entry_addr[rd_index];
            profiler_bus_pkg::field_valid: rd_data = data_width'(entry_valid[rd_index]);
            profiler_bus_pkg::field_count: rd_data = data_width'(entry_count[rd_index]);
            default:                       rd_data = '0;
        endcase
    end

    always_comb begin
        for (int i = 0; i < num_entries; i++)
            over_thresh[i] = int'(entry_count[i]) >= hot_threshold;
    end

    // Fire on a new crossing and never two cycles in a row
    always_ff @(posedge clk) begin
        if (rst) begin
            over_thresh_q <= '0;
            hot_irq       <= 1'b0;
        end else begin
            over_thresh_q <= over_thresh;
            hot_irq       <= (|(over_thresh & ~over_thresh_q)) && !hot_irq;
        end
    end

endmodule

`default_nettype wire

// ==== hw/axil_reg_decode.sv ====
`default_nettype none

module axil_reg_decode #(
    parameter int num_entries = 8
) (
    input  wire                                clk,
    input  wire                                rst,

    input  wire                                s_axil_awvalid,
    output logic                               s_axil_awready,
    input  wire  [profiler_cfg_pkg::xlen-1:0]  s_axil_awaddr,
    input  wire                                s_axil_wvalid,
    output logic                               s_axil_wready,
    input  wire  [profiler_cfg_pkg::xlen-1:0]  s_axil_wdata,
    output logic                               s_axil_bvalid,
    output logic [1:0]                         s_axil_bresp,
    input  wire                                s_axil_bready,

    input  wire                                s_axil_arvalid,
    output logic                               s_axil_arready,
    input  wire  [profiler_cfg_pkg::xlen-1:0]  s_axil_araddr,

    input  wire                                rd_busy,
    output logic                               rd_req,
    output logic                               rd_is_ctrl,
    output logic [3:0]                         rd_reg_sel,
    output logic [$clog2(num_entries)-1:0]     rd_index,
    output logic [1:0]                         rd_field,
    output logic                               lock
);

    localparam int index_width = $clog2(num_entries);

    profiler_bus_pkg::prof_addr_u aw_view;
    profiler_bus_pkg::prof_addr_u ar_view;

    logic wr_ready;
    logic wr_fire;
    logic ar_fire;

    assign aw_view = s_axil_awaddr[profiler_bus_pkg::map_bits-1:0];
    assign ar_view = s_axil_araddr[profiler_bus_pkg::map_bits-1:0];

    // Address and data are taken together
    assign s_axil_awready = wr_ready;
    assign s_axil_wready  = wr_ready;
    assign wr_fire = wr_ready && s_axil_awvalid && s_axil_wvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready      <= 1'b0;
            s_axil_bvalid <= 1'b0;
        end else begin
            wr_ready <= s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid && !wr_ready;
            if (wr_fire)
                s_axil_bvalid <= 1'b1;
            else if (s_axil_bready)
                s_axil_bvalid <= 1'b0;
        end
    end

    // Table entries are read only
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            if (aw_view.ctrl.region)
                s_axil_bresp <= profiler_bus_pkg::axi_resp_okay;
            else
                s_axil_bresp <= profiler_bus_pkg::axi_resp_slverr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            lock <= 1'b1;
        else if (wr_fire && aw_view.ctrl.region && aw_view.ctrl.sel == profiler_bus_pkg::reg_lock)
            lock <= s_axil_wdata[0];
    end

    // One read in flight at most
    assign s_axil_arready = !rd_busy && !rd_req;
    assign ar_fire = s_axil_arvalid && s_axil_arready;

    always_ff @(posedge clk) begin
        if (rst)
            rd_req <= 1'b0;
        else
            rd_req <= ar_fire;
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_is_ctrl <= ar_view.ctrl.region;
            rd_reg_sel <= ar_view.ctrl.sel;
            // Index wraps onto the table size
            rd_index   <= ar_view.entry.index[index_width-1:0];
            rd_field   <= ar_view.entry.field;
        end
    end

endmodule

`default_nettype wire

// ==== common/profiler_bus_pkg.sv ====
`default_nettype none

package profiler_bus_pkg;

    localparam logic [1:0] axi_resp_okay   = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

    // Entry fields
    localparam logic [1:0] field_addr  = 2'd0;
    localparam logic [1:0] field_valid = 2'd1;
    localparam logic [1:0] field_count = 2'd2;

    // Control registers
    localparam logic [3:0] reg_lock = 4'd0;
    localparam logic [3:0] reg_info = 4'd1;

    // Low address bits seen by the decoder
    localparam int map_bits          = 12;
    localparam int entry_spare_width = map_bits - 5 - profiler_cfg_pkg::max_index_width;

    typedef struct packed {
        logic                                         region;
        logic [entry_spare_width-1:0]                 spare;
        logic [profiler_cfg_pkg::max_index_width-1:0] index;
        logic [1:0]                                   field;
        logic [1:0]                                   byte_off;
    } entry_addr_t;

    typedef struct packed {
        logic       region;
        logic [4:0] spare;
        logic [3:0] sel;
        logic [1:0] byte_off;
    } ctrl_addr_t;

    // Region bit picks the view
    typedef union packed {
        entry_addr_t entry;
        ctrl_addr_t  ctrl;
    } prof_addr_u;

endpackage

`default_nettype wire

// ==== common/profiler_cfg_pkg.sv ====
`default_nettype none

package profiler_cfg_pkg;

    // Address and data width of the core
    localparam int xlen = 32;

    // Table geometry defaults
    localparam int default_num_entries = 8;
    localparam int default_count_width = 4;

    // Largest backward distance still counted as a loop, in bytes
    localparam int default_sbb_max_back = 256;

    // Count at which the hot loop interrupt fires
    localparam int default_hot_threshold = 12;

    // Index bits reserved in the AXI address map cap the table at 64 entries
    localparam int max_index_width = 6;

endpackage

`default_nettype wire
